// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fdc_write
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== fdc_pkg.sv ====
`default_nettype none

package fdc_pkg;

    // Tag carried with every queue entry.
    typedef enum logic [1:0] {
        KIND_DATA = 2'd0,
        KIND_MA1  = 2'd1,
        KIND_MC2  = 2'd2,
        KIND_CRC  = 2'd3
    } entry_kind_t;

    // Kind in the top two bits, payload byte below.
    localparam int ENTRY_W = 10;

    // Byte values that marks contribute to the CRC.
    localparam logic [7:0] MARK_A1_BYTE = 8'hA1;
    localparam logic [7:0] MARK_C2_BYTE = 8'hC2;

    // CRC-CCITT as used on floppy address and data fields.
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'h1021;

endpackage

`default_nettype wire

// ==== fdc_write_top.sv ====
`default_nettype none

module fdc_write_top import fdc_pkg::*; #(
    parameter int QUEUE_DEPTH = 16,
    parameter int CELL_DIV    = 8,
    parameter int PULSE_LEN   = 2
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        wr_push,
    input  wire entry_kind_t wr_kind,
    input  wire logic [7:0]  wr_data,
    input  wire logic        abort,
    output logic             queue_full,
    output logic             write_gate,
    output logic             write_pulse,
    output logic             tx_idle
);

    entry_kind_t head_kind;
    logic [7:0]  head_data;
    logic        queue_empty;
    logic        pop;
    logic [7:0]  txdat;
    logic        txwr;
    logic        txma1;
    logic        txmc2;
    logic        txemp;
    logic        txend;
    logic        sft;
    logic        bitout;
    logic        writeen;

    tx_byte_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .rstn(rstn), .push(wr_push), .push_kind(wr_kind), .push_data(wr_data),
        .pop(pop), .head_kind(head_kind), .head_data(head_data),
        .full(queue_full), .empty(queue_empty)
    );

    tx_feeder u_feeder (
        .clk(clk), .rstn(rstn), .brk(abort), .head_kind(head_kind), .head_data(head_data),
        .empty(queue_empty), .txemp(txemp), .pop(pop), .txdat(txdat),
        .txwr(txwr), .txma1(txma1), .txmc2(txmc2)
    );

    mfmmod u_mfm (
        .txdat(txdat), .txwr(txwr), .txma1(txma1), .txmc2(txmc2), .brk(abort), .sft(sft),
        .clk(clk), .rstn(rstn), .txemp(txemp), .txend(txend), .bitout(bitout),
        .writeen(writeen)
    );

    mfm_write_timer #(.CELL_DIV(CELL_DIV), .PULSE_LEN(PULSE_LEN)) u_timer (
        .clk(clk), .rstn(rstn), .bitout(bitout), .writeen(writeen),
        .sft(sft), .write_pulse(write_pulse), .write_gate(write_gate)
    );

    assign tx_idle = txend;

endmodule

`default_nettype wire

// ==== list.f ====
fdc_pkg.sv
tx_byte_queue.sv
tx_feeder.sv
mfmmod.sv
mfm_write_timer.sv
fdc_write_top.sv
tb_fdc_write.sv

// ==== mfm_write_timer.sv ====
`default_nettype none

module mfm_write_timer #(
    parameter int CELL_DIV  = 8,
    parameter int PULSE_LEN = 2
) (
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic bitout,
    input  wire logic writeen,
    output logic      sft,
    output logic      write_pulse,
    output logic      write_gate
);

    localparam int DIV_W   = (CELL_DIV > 1) ? $clog2(CELL_DIV) : 1;
    localparam int PULSE_W = $clog2(PULSE_LEN + 1);

    logic [DIV_W-1:0]   div_cnt;
    logic [PULSE_W-1:0] pulse_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt <= '0;
        end else if (sft) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sft = (div_cnt == DIV_W'(CELL_DIV - 1)); // One clock per cell.

    // The pulse starts with bitout and the counter holds the remaining cycles.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pulse_cnt <= '0;
        end else if (bitout) begin
            pulse_cnt <= PULSE_W'(PULSE_LEN - 1);
        end else if (pulse_cnt != '0) begin
            pulse_cnt <= pulse_cnt - 1'b1;
        end
    end

    assign write_pulse = bitout || (pulse_cnt != '0);
    assign write_gate  = writeen;

    a_pulse_done: assert property (@(posedge clk) disable iff (!rstn)
        bitout |-> (pulse_cnt == '0));

endmodule

`default_nettype wire

// ==== mfmmod.sv ====
`default_nettype none

module mfmmod (
    input  wire logic [7:0] txdat,
    input  wire logic       txwr,
    input  wire logic       txma1,
    input  wire logic       txmc2,
    input  wire logic       brk,
    input  wire logic       sft,
    input  wire logic       clk,
    input  wire logic       rstn,
    output logic            txemp,
    output logic            txend,
    output logic            bitout,
    output logic            writeen
);

    // Marks with one clock bit left out.
    localparam logic [14:0] PAT_A1 = 15'b100010010001001;
    localparam logic [14:0] PAT_C2 = 15'b101001000100100;

    logic [14:0] enc_byte;
    logic [14:0] nxt_sft;
    logic [14:0] cur_sft;
    logic        nxt_emp;
    logic [3:0]  cell_cnt;
    logic        take_next;
    logic        last_lsb;
    logic        any_strobe;

    // Data bits on even positions, MSB at the top.
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            enc_byte[2*i]   = txdat[i];
            enc_byte[2*i+1] = !txdat[i] && !txdat[i+1];
        end
        enc_byte[14] = txdat[7];
    end

    assign any_strobe = txwr || txma1 || txmc2;
    assign txemp      = nxt_emp && !any_strobe;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            nxt_emp <= 1'b1;
            nxt_sft <= '0;
        end else if (brk) begin
            nxt_emp <= 1'b1;
            nxt_sft <= '0;
        end else if (nxt_emp) begin
            if (txwr) begin
                nxt_sft <= enc_byte;
                nxt_emp <= 1'b0;
            end else if (txma1) begin
                nxt_sft <= PAT_A1;
                nxt_emp <= 1'b0;
            end else if (txmc2) begin
                nxt_sft <= PAT_C2;
                nxt_emp <= 1'b0;
            end
        end else if (take_next) begin
            nxt_emp <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_sft   <= '1;
            cell_cnt  <= '0;
            take_next <= 1'b0;
            last_lsb  <= 1'b1;
            bitout    <= 1'b0;
            writeen   <= 1'b0;
            txend     <= 1'b1;
        end else begin
            bitout    <= 1'b0;
            take_next <= 1'b0;
            if (brk) begin
                cell_cnt <= '0;
                last_lsb <= 1'b1;
                writeen  <= 1'b0;
                txend    <= 1'b1;
            end else if (sft) begin
                if (cell_cnt != '0) begin
                    bitout   <= cur_sft[14];
                    cur_sft  <= {cur_sft[13:0], 1'b1};
                    cell_cnt <= cell_cnt - 1'b1;
                end else if (!nxt_emp) begin
                    // Boundary clock from the previous last data bit.
                    bitout    <= !last_lsb && !nxt_sft[14];
                    cur_sft   <= nxt_sft;
                    last_lsb  <= nxt_sft[0];
                    cell_cnt  <= 4'd15;
                    take_next <= 1'b1;
                    writeen   <= 1'b1;
                    txend     <= 1'b0;
                end else begin
                    writeen <= 1'b0; // Underrun ends the write.
                    txend   <= 1'b1;
                end
            end
        end
    end

    a_strobe_when_empty: assert property (@(posedge clk) disable iff (!rstn)
        (any_strobe && !brk) |-> nxt_emp);

endmodule

`default_nettype wire

// ==== tb_fdc_write.sv ====
`default_nettype none

module tb_fdc_write import fdc_pkg::*; ();

    localparam int QUEUE_DEPTH = 16;
    localparam int CELL_DIV    = 8;
    localparam int PULSE_LEN   = 2;
    localparam int WAIT_LIMIT  = 2000;

    logic        clk;
    logic        rstn;
    logic        wr_push;
    entry_kind_t wr_kind;
    logic [7:0]  wr_data;
    logic        abort;
    logic        queue_full;
    logic        write_gate;
    logic        write_pulse;
    logic        tx_idle;

    integer      seed = 98500;
    entry_kind_t push_kinds[$];
    logic [7:0]  push_bytes[$];
    bit          exp_cells[$];
    logic        prev_bit;   // Last data bit written, for the boundary clock.
    logic [15:0] crc_model;

    fdc_write_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .CELL_DIV(CELL_DIV),
        .PULSE_LEN(PULSE_LEN)
    ) uut (
        .clk(clk),
        .rstn(rstn),
        .wr_push(wr_push),
        .wr_kind(wr_kind),
        .wr_data(wr_data),
        .abort(abort),
        .queue_full(queue_full),
        .write_gate(write_gate),
        .write_pulse(write_pulse),
        .tx_idle(tx_idle)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic crc_update(input logic [7:0] b);
        crc_model = crc_model ^ {b, 8'h00};
        for (int k = 0; k < 8; k++) begin
            if (crc_model[15]) begin
                crc_model = {crc_model[14:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc_model = {crc_model[14:0], 1'b0};
            end
        end
    endtask

    // Clock cell before each data bit is 1 only between two zero bits.
    task automatic expand_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            exp_cells.push_back(!prev_bit && !b[i]);
            exp_cells.push_back(b[i]);
            prev_bit = b[i];
        end
    endtask

    task automatic expand_mark(input logic [15:0] pattern);
        exp_cells.push_back(!prev_bit && !pattern[14]);
        for (int i = 14; i >= 0; i--) begin
            exp_cells.push_back(pattern[i]);
        end
        prev_bit = pattern[0]; // The last cell of a mark is its last data bit.
    endtask

    task automatic add_entry(input entry_kind_t kind, input logic [7:0] b);
        push_kinds.push_back(kind);
        push_bytes.push_back(b);
        case (kind)
            KIND_MA1: begin
                crc_update(MARK_A1_BYTE);
                expand_mark(16'h4489);
            end
            KIND_MC2: begin
                crc_update(MARK_C2_BYTE);
                expand_mark(16'h5224);
            end
            KIND_CRC: begin
                expand_byte(crc_model[15:8]);
                expand_byte(crc_model[7:0]);
                crc_model = CRC_INIT;
            end
            default: begin
                crc_update(b);
                expand_byte(b);
            end
        endcase
    endtask

    task automatic push_entries();
        foreach (push_kinds[i]) begin
            wr_push = 1'b1;
            wr_kind = push_kinds[i];
            wr_data = push_bytes[i];
            @(negedge clk);
        end
        wr_push = 1'b0;
        push_kinds.delete();
        push_bytes.delete();
    endtask

    task automatic wait_gate(input logic level);
        int n;
        n = 0;
        while (write_gate !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_run("write_gate did not reach the expected level in time");
            end
        end
    endtask

    // Entered on the first falling edge of cell 0.
    task automatic sample_cells();
        logic seen;
        foreach (exp_cells[i]) begin
            check("write_gate", 1'b1, write_gate);
            seen = 1'b0;
            repeat (CELL_DIV) begin
                seen = seen | write_pulse;
                @(negedge clk);
            end
            check($sformatf("write_pulse cell %0d", i), exp_cells[i], seen);
        end
        check("write_gate", 1'b0, write_gate);
        check("tx_idle", 1'b1, tx_idle);
        exp_cells.delete();
    endtask

    task automatic run_record();
        fork
            push_entries();
            begin
                wait_gate(1'b1);
                sample_cells();
            end
        join
    endtask

    task automatic test_reset_state();
        check("write_gate", 1'b0, write_gate);
        check("write_pulse", 1'b0, write_pulse);
        check("queue_full", 1'b0, queue_full);
        check("tx_idle", 1'b1, tx_idle);
    endtask

    task automatic test_data_bytes();
        repeat (8) begin
            add_entry(KIND_DATA, 8'($random(seed)));
        end
        run_record();
    endtask

    task automatic test_marks();
        repeat (3) begin
            add_entry(KIND_MA1, MARK_A1_BYTE);
        end
        add_entry(KIND_DATA, 8'($random(seed)));
        add_entry(KIND_MC2, MARK_C2_BYTE);
        run_record();
    endtask

    task automatic test_sector_crc();
        abort = 1'b1; // Clears the running CRC so the record starts clean.
        @(negedge clk);
        abort = 1'b0;
        prev_bit = 1'b1;
        crc_model = CRC_INIT;
        repeat (3) begin
            add_entry(KIND_MA1, MARK_A1_BYTE);
        end
        add_entry(KIND_DATA, 8'hFE);
        repeat (4) begin
            add_entry(KIND_DATA, 8'($random(seed)));
        end
        add_entry(KIND_CRC, 8'h00);
        run_record();
    endtask

    task automatic test_abort();
        int n;
        // A stale last bit of 0 would set the clock before the next record.
        add_entry(KIND_DATA, 8'($random(seed)) & 8'hFE);
        add_entry(KIND_DATA, 8'($random(seed)));
        fork
            push_entries();
            wait_gate(1'b1);
        join
        repeat (5 * CELL_DIV + 3) @(negedge clk);
        abort = 1'b1;
        n = 0;
        while (write_gate !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 2) begin
                fail_run("write_gate stayed high after abort");
            end
        end
        check("tx_idle", 1'b1, tx_idle);
        @(negedge clk);
        abort = 1'b0;
        exp_cells.delete();
        prev_bit = 1'b1;
        crc_model = CRC_INIT;
        add_entry(KIND_DATA, 8'($random(seed)) & 8'h7F);
        add_entry(KIND_MA1, MARK_A1_BYTE);
        add_entry(KIND_DATA, 8'($random(seed)));
        add_entry(KIND_CRC, 8'h00);
        run_record();
    endtask

    task automatic test_queue_full();
        abort = 1'b1;
        prev_bit = 1'b1;
        crc_model = CRC_INIT;
        for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            add_entry(KIND_DATA, 8'($random(seed)));
        end
        add_entry(KIND_CRC, 8'h00);
        push_entries();
        check("queue_full", 1'b1, queue_full);
        check("write_gate", 1'b0, write_gate);
        abort = 1'b0;
        wait_gate(1'b1);
        sample_cells();
        check("queue_full", 1'b0, queue_full);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        wr_push = 1'b0;
        wr_kind = KIND_DATA;
        wr_data = 8'h00;
        abort = 1'b0;
        prev_bit = 1'b1;
        crc_model = CRC_INIT;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        test_reset_state();
        test_data_bytes();
        test_marks();
        test_sector_crc();
        test_abort();
        test_queue_full();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tx_byte_queue.sv ====
`default_nettype none

module tx_byte_queue import fdc_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        push,
    input  wire entry_kind_t push_kind,
    input  wire logic [7:0]  push_data,
    input  wire logic        pop,
    output entry_kind_t      head_kind,
    output logic [7:0]       head_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full; // A push into a full queue is lost.
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_kind, push_data};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head_kind = entry_kind_t'(mem[rd_ptr][ENTRY_W-1:8]);
    assign head_data = mem[rd_ptr][7:0];
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);

    // The host watches queue_full and the feeder watches queue_empty.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

`default_nettype wire

// ==== tx_feeder.sv ====
`default_nettype none

module tx_feeder import fdc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        brk,
    input  wire entry_kind_t head_kind,
    input  wire logic [7:0]  head_data,
    input  wire logic        empty,
    input  wire logic        txemp,
    output logic             pop,
    output logic [7:0]       txdat,
    output logic             txwr,
    output logic             txma1,
    output logic             txmc2
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND_HI,
        ST_SEND_LO
    } feed_state_t;

    feed_state_t state;
    logic [15:0] crc;
    logic        head_ready;

    // MSB-first CRC step over one byte.
    function automatic logic [15:0] crc_byte(input logic [15:0] crc_in, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[15] ^ b[i];
            c  = {c[14:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // The head is stale in the cycle of a pop, so it is skipped then.
    assign head_ready = !empty && !pop;

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            txdat <= head_data;
        end else if (state == ST_SEND_HI) begin
            txdat <= crc[15:8];
        end else begin
            txdat <= crc[7:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
            crc   <= CRC_INIT;
            pop   <= 1'b0;
            txwr  <= 1'b0;
            txma1 <= 1'b0;
            txmc2 <= 1'b0;
        end else begin
            pop   <= 1'b0;
            txwr  <= 1'b0;
            txma1 <= 1'b0;
            txmc2 <= 1'b0;
            if (brk) begin
                state <= ST_IDLE;
                crc   <= CRC_INIT;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (head_ready && head_kind == KIND_CRC) begin
                            state <= ST_SEND_HI;
                        end else if (head_ready && txemp) begin
                            pop <= 1'b1;
                            case (head_kind)
                                KIND_MA1: begin
                                    txma1 <= 1'b1;
                                    crc   <= crc_byte(crc, MARK_A1_BYTE);
                                end
                                KIND_MC2: begin
                                    txmc2 <= 1'b1;
                                    crc   <= crc_byte(crc, MARK_C2_BYTE);
                                end
                                default: begin
                                    txwr <= 1'b1;
                                    crc  <= crc_byte(crc, head_data);
                                end
                            endcase
                        end
                    end
                    ST_SEND_HI: begin
                        if (txemp) begin
                            txwr  <= 1'b1;
                            state <= ST_SEND_LO;
                        end
                    end
                    default: begin
                        if (txemp) begin
                            txwr  <= 1'b1;
                            pop   <= 1'b1; // The CRC entry leaves with its second byte.
                            crc   <= CRC_INIT;
                            state <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // One strobe per refill of the modulator, never two in a row.
    a_one_strobe: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({txwr, txma1, txmc2, $past(txwr || txma1 || txmc2)}));

endmodule

`default_nettype wire
